//--- design/axi_pkg.sv
`include "axi_bridge_settings.svh"

package axi_pkg;

    // burst encodings, WRAP not used by the bridge
    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01
    } axi_burst_t;

    // bytes per beat as log2
    typedef enum logic [2:0] {
        SIZE_BYTE = 3'b000,
        SIZE_HALF = 3'b001,
        SIZE_WORD = 3'b010
    } axi_size_t;

    // shared by ar and aw
    typedef struct packed {
        logic [`ADDR_W-1:0] addr;
        logic [7:0]         len;
        axi_size_t          size;
        axi_burst_t         burst;
    } axi_addr_t;

    // one data beat on r or w
    typedef struct packed {
        logic [`DATA_W-1:0] data;
        logic               last;
    } axi_beat_t;

endpackage

//--- design/block_beat_buffer.sv
`timescale 1ns/1ps

`include "axi_bridge_settings.svh"

module block_beat_buffer (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        capture,
    input  logic                        beat_step,
    input  logic                        load_done,
    input  cache_req_pkg::cache_block_t wblock,
    input  axi_pkg::axi_beat_t          r,
    output axi_pkg::axi_beat_t          w,
    output cache_req_pkg::cache_block_t rblock,
    output logic [`DATA_W-1:0]          rword
);

    localparam int CNT_W = $clog2(`BLOCK_BEATS);

    cache_req_pkg::cache_block_t shift_q;
    logic [CNT_W-1:0]            beat_cnt;
    logic [CNT_W-1:0]            first_idx;
    logic                        block_full;
    logic [`DATA_W-1:0]          rword_q;

    // write beats leave at the bottom and read beats enter at the top
    always_ff @(posedge clk) begin
        if (capture) begin
            shift_q <= wblock;
        end else if (beat_step) begin
            shift_q <= {r.data, shift_q[`BLOCK_W-1:`DATA_W]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            beat_cnt   <= '0;
            block_full <= 1'b0;
        end else if (capture) begin
            beat_cnt   <= '0;
            block_full <= 1'b0;
        end else if (beat_step) begin
            beat_cnt <= beat_cnt + CNT_W'(1);
            if (beat_cnt == '1) begin
                block_full <= 1'b1;
            end
        end
    end

    assign w.data = shift_q[`DATA_W-1:0];
    assign w.last = beat_cnt == CNT_W'(`BLOCK_BEATS - 1);

    assign rblock = shift_q;

    // after n beats the first one sits at word (8 - n) mod 8
    assign first_idx = -beat_cnt;

    always_ff @(posedge clk) begin
        if (load_done) begin
            rword_q <= shift_q[first_idx * `DATA_W +: `DATA_W];
        end
    end

    // bypass so rword is ready together with task_finish
    assign rword = load_done ? shift_q[first_idx * `DATA_W +: `DATA_W] : rword_q;

    a_beat_limit: assert property (@(posedge clk) disable iff (!rstn)
        block_full |-> !beat_step);

endmodule

//--- design/burst_sequencer.sv
`timescale 1ns/1ps

module burst_sequencer (
    input  logic                           clk,
    input  logic                           rstn,
    input  cache_req_pkg::cache_req_code_t req,
    input  cache_req_pkg::cache_cmd_t      cmd,
    input  logic                           arready,
    input  logic                           awready,
    input  logic                           wready,
    input  logic                           rvalid,
    input  logic                           rlast,
    input  logic                           bvalid,
    output logic                           capture,
    output logic                           beat_step,
    output logic                           load_done,
    output logic                           arvalid,
    output logic                           awvalid,
    output logic                           wvalid,
    output logic                           rready,
    output logic                           bready,
    output logic                           task_finish
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_DATA,
        ST_RESP
    } state_t;

    state_t     state;
    state_t     state_nxt;
    logic [2:0] beat_cnt;
    logic       is_store;
    logic       last_beat;
    logic       ar_fire;
    logic       aw_fire;
    logic       r_fire;
    logic       w_fire;
    logic       b_fire;
    logic       load_end;

    assign is_store  = cmd.kind == cache_req_pkg::KIND_STORE_BLOCK;
    assign last_beat = beat_cnt == cmd.addr.len[2:0];

    // the finish cycle still belongs to the old transaction
    assign capture = (state == ST_IDLE) && !task_finish && (req != cache_req_pkg::REQ_IDLE);

    // channel controls decode from registered state only
    assign arvalid = (state == ST_ADDR) && !is_store;
    assign awvalid = (state == ST_ADDR) && is_store;
    assign rready  = ((state == ST_ADDR) || (state == ST_DATA)) && !is_store;
    assign wvalid  = (state == ST_DATA) && is_store;
    assign bready  = state == ST_RESP;

    assign ar_fire = arvalid && arready;
    assign aw_fire = awvalid && awready;
    assign r_fire  = rvalid && rready;
    assign w_fire  = wvalid && wready;
    assign b_fire  = bvalid && bready;

    assign beat_step = (state == ST_DATA) && (r_fire || w_fire);
    assign load_end  = (state == ST_DATA) && r_fire && last_beat;

    always_comb begin
        state_nxt = state;
        unique case (state)
            ST_IDLE: begin
                if (capture) begin
                    state_nxt = ST_ADDR;
                end
            end
            ST_ADDR: begin
                if (ar_fire || aw_fire) begin
                    state_nxt = ST_DATA;
                end
            end
            ST_DATA: begin
                if (load_end) begin
                    state_nxt = ST_IDLE;
                end else if (w_fire && last_beat) begin
                    state_nxt = ST_RESP;
                end
            end
            ST_RESP: begin
                if (b_fire) begin
                    state_nxt = ST_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state       <= ST_IDLE;
            beat_cnt    <= 3'd0;
            task_finish <= 1'b0;
            load_done   <= 1'b0;
        end else begin
            state       <= state_nxt;
            task_finish <= load_end || b_fire;
            load_done   <= load_end;
            if (capture) begin
                beat_cnt <= 3'd0;
            end else if (beat_step) begin
                beat_cnt <= beat_cnt + 3'd1;
            end
        end
    end

    // address valid and payload hold until accepted
    a_ar_hold: assert property (@(posedge clk) disable iff (!rstn)
        arvalid && !arready |=> arvalid && $stable(cmd));
    a_aw_hold: assert property (@(posedge clk) disable iff (!rstn)
        awvalid && !awready |=> awvalid && $stable(cmd));

    // slave's rlast must match the requested length
    a_rlast_count: assert property (@(posedge clk) disable iff (!rstn)
        (state == ST_DATA) && r_fire |-> rlast == last_beat);

endmodule

//--- design/cache_axi_bridge.sv
`timescale 1ns/1ps

`include "axi_bridge_settings.svh"

module cache_axi_bridge (
    input  logic                           clk,
    input  logic                           rstn,
    input  cache_req_pkg::cache_req_code_t req,
    input  cache_req_pkg::cache_block_t    wblock,
    input  logic [`ADDR_W-1:0]             ad,
    input  logic [3:0]                     rword_en,
    output logic                           task_finish,
    output cache_req_pkg::cache_block_t    rblock,
    output logic [`DATA_W-1:0]             rword,
    output axi_pkg::axi_addr_t             ar,
    output logic                           arvalid,
    input  logic                           arready,
    output axi_pkg::axi_addr_t             aw,
    output logic                           awvalid,
    input  logic                           awready,
    output logic [`AXI_ID_W-1:0]           arid,
    output logic [`AXI_ID_W-1:0]           awid,
    output logic [`AXI_ID_W-1:0]           wid,
    output logic [`AXI_LOCK_W-1:0]         arlock,
    output logic [`AXI_CACHE_W-1:0]        arcache,
    output logic [`AXI_PROT_W-1:0]         arprot,
    output logic [`AXI_LOCK_W-1:0]         awlock,
    output logic [`AXI_CACHE_W-1:0]        awcache,
    output logic [`AXI_PROT_W-1:0]         awprot,
    input  axi_pkg::axi_beat_t             r,
    input  logic                           rvalid,
    output logic                           rready,
    output axi_pkg::axi_beat_t             w,
    output logic [`AXI_STRB_W-1:0]         wstrb,
    output logic                           wvalid,
    input  logic                           wready,
    input  logic                           bvalid,
    output logic                           bready
);

    cache_req_pkg::cache_cmd_t cmd;
    logic                      capture;
    logic                      beat_step;
    logic                      load_done;

    // one address register feeds both channels, valids pick the one in use
    assign ar = cmd.addr;
    assign aw = cmd.addr;

    assign arid    = `AXI_READ_ID;
    assign awid    = `AXI_WRITE_ID;
    assign wid     = `AXI_WRITE_ID;
    assign arlock  = `AXI_LOCK_CODE;
    assign awlock  = `AXI_LOCK_CODE;
    assign arcache = `AXI_CACHE_CODE;
    assign awcache = `AXI_CACHE_CODE;
    assign arprot  = `AXI_PROT_CODE;
    assign awprot  = `AXI_PROT_CODE;
    // full-word block stores only
    assign wstrb   = '1;

    req_decoder u_req_decoder (
        .clk      (clk),
        .rstn     (rstn),
        .req      (req),
        .ad       (ad),
        .rword_en (rword_en),
        .capture  (capture),
        .cmd      (cmd)
    );

    burst_sequencer u_burst_sequencer (
        .clk         (clk),
        .rstn        (rstn),
        .req         (req),
        .cmd         (cmd),
        .arready     (arready),
        .awready     (awready),
        .wready      (wready),
        .rvalid      (rvalid),
        .rlast       (r.last),
        .bvalid      (bvalid),
        .capture     (capture),
        .beat_step   (beat_step),
        .load_done   (load_done),
        .arvalid     (arvalid),
        .awvalid     (awvalid),
        .wvalid      (wvalid),
        .rready      (rready),
        .bready      (bready),
        .task_finish (task_finish)
    );

    block_beat_buffer u_block_beat_buffer (
        .clk       (clk),
        .rstn      (rstn),
        .capture   (capture),
        .beat_step (beat_step),
        .load_done (load_done),
        .wblock    (wblock),
        .r         (r),
        .w         (w),
        .rblock    (rblock),
        .rword     (rword)
    );

endmodule

//--- design/cache_req_pkg.sv
`include "axi_bridge_settings.svh"

package cache_req_pkg;

    // level code driven by the cache
    typedef enum logic [1:0] {
        REQ_IDLE        = 2'b00,
        REQ_LOAD_BLOCK  = 2'b01,
        REQ_LOAD_WORD   = 2'b10,
        REQ_STORE_BLOCK = 2'b11
    } cache_req_code_t;

    // kind of the transaction in flight
    typedef enum logic [1:0] {
        KIND_LOAD_BLOCK  = 2'b00,
        KIND_LOAD_WORD   = 2'b01,
        KIND_STORE_BLOCK = 2'b10
    } cache_kind_t;

    typedef logic [`BLOCK_W-1:0] cache_block_t;

    // captured command, address fields go straight to ar/aw
    typedef struct packed {
        cache_kind_t       kind;
        axi_pkg::axi_addr_t addr;
    } cache_cmd_t;

endpackage

//--- design/req_decoder.sv
`timescale 1ns/1ps

`include "axi_bridge_settings.svh"

module req_decoder (
    input  logic                           clk,
    input  logic                           rstn,
    input  cache_req_pkg::cache_req_code_t req,
    input  logic [`ADDR_W-1:0]             ad,
    input  logic [3:0]                     rword_en,
    input  logic                           capture,
    output cache_req_pkg::cache_cmd_t      cmd
);

    // byte offset inside one cache block
    localparam int OFFSET_W = $clog2(`BLOCK_W / 8);

    axi_pkg::axi_size_t        word_size;
    cache_req_pkg::cache_cmd_t cmd_nxt;

    // byte enables to beat size
    always_comb begin
        unique case (rword_en)
            4'b1111: word_size = axi_pkg::SIZE_WORD;
            4'b1100,
            4'b0011: word_size = axi_pkg::SIZE_HALF;
            default: word_size = axi_pkg::SIZE_BYTE;
        endcase
    end

    always_comb begin
        // block burst unless a word load
        cmd_nxt.kind       = cache_req_pkg::KIND_LOAD_BLOCK;
        cmd_nxt.addr.addr  = {ad[`ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        cmd_nxt.addr.len   = 8'(`BLOCK_BEATS - 1);
        cmd_nxt.addr.size  = axi_pkg::SIZE_WORD;
        cmd_nxt.addr.burst = axi_pkg::BURST_INCR;
        if (req == cache_req_pkg::REQ_STORE_BLOCK) begin
            cmd_nxt.kind = cache_req_pkg::KIND_STORE_BLOCK;
        end else if (req == cache_req_pkg::REQ_LOAD_WORD) begin
            cmd_nxt.kind       = cache_req_pkg::KIND_LOAD_WORD;
            cmd_nxt.addr.addr  = ad;
            cmd_nxt.addr.len   = 8'd0;
            cmd_nxt.addr.size  = word_size;
            cmd_nxt.addr.burst = axi_pkg::BURST_FIXED;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            cmd <= cmd_nxt;
        end
    end

    // sequencer only captures on a real request
    a_capture_not_idle: assert property (@(posedge clk) disable iff (!rstn)
        capture |-> req != cache_req_pkg::REQ_IDLE);

endmodule

//--- include/axi_bridge_settings.svh
`ifndef AXI_BRIDGE_SETTINGS_SVH
`define AXI_BRIDGE_SETTINGS_SVH

// bus and block geometry
`define ADDR_W        32
`define DATA_W        32
`define BLOCK_BEATS   8
`define BLOCK_W       256
`define AXI_STRB_W    (`DATA_W / 8)

// side-band field widths
`define AXI_ID_W      4
`define AXI_LOCK_W    2
`define AXI_CACHE_W   4
`define AXI_PROT_W    3

// fixed transaction attributes
`define AXI_READ_ID     4'h0
`define AXI_WRITE_ID    4'h1
`define AXI_CACHE_CODE  4'b0011
`define AXI_PROT_CODE   3'b000
`define AXI_LOCK_CODE   2'b00

`endif

//--- project.f
+incdir+include
design/axi_pkg.sv
design/cache_req_pkg.sv
design/req_decoder.sv
design/burst_sequencer.sv
design/block_beat_buffer.sv
design/cache_axi_bridge.sv
testbench/axi_slave_model.sv
testbench/tb_cache_axi_bridge.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_cache_axi_bridge \
    -f project.f -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Done: errors found" sim.log; then
    exit 1
fi
if ! grep -q "Done: no errors" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0

//--- testbench/axi_slave_model.sv
`timescale 1ns/1ps

`include "axi_bridge_settings.svh"

module axi_slave_model #(
    parameter logic [31:0] PATTERN_KEY = 32'h0,
    parameter logic [31:0] SEED        = 32'hec9b_3652
) (
    input  logic               clk,
    input  logic               rstn,
    input  axi_pkg::axi_addr_t ar,
    input  logic               arvalid,
    output logic               arready,
    input  logic               awvalid,
    output logic               awready,
    output axi_pkg::axi_beat_t r,
    output logic               rvalid,
    input  logic               rready,
    input  axi_pkg::axi_beat_t w,
    input  logic               wvalid,
    output logic               wready,
    output logic               bvalid,
    input  logic               bready
);

    logic [31:0] rnd;
    logic [31:0] rnd_v;
    logic [31:0] rd_addr;
    logic [7:0]  rd_left;
    logic        rd_fixed;
    logic        rd_pend;
    logic        r_taken;
    logic        b_pend;
    logic        b_taken;

    // right-shift Galois form stepped once per random bit
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
    endfunction

    // transfers are seen on the rising edge
    always @(posedge clk) begin
        if (!rstn) begin
            rd_pend <= 1'b0;
            r_taken <= 1'b0;
            b_pend  <= 1'b0;
            b_taken <= 1'b0;
        end else begin
            r_taken <= rvalid && rready;
            b_taken <= bvalid && bready;
            if (arvalid && arready) begin
                rd_pend  <= 1'b1;
                rd_addr  <= ar.addr;
                rd_left  <= ar.len;
                rd_fixed <= ar.burst == axi_pkg::BURST_FIXED;
            end
            if (rvalid && rready) begin
                if (rd_left == 8'd0) begin
                    rd_pend <= 1'b0;
                end else begin
                    rd_left <= rd_left - 8'd1;
                    if (!rd_fixed) begin
                        rd_addr <= rd_addr + 32'd4;
                    end
                end
            end
            if (wvalid && wready) begin
                if (w.last) begin
                    b_pend <= 1'b1;
                end
            end
            if (bvalid && bready) begin
                b_pend <= 1'b0;
            end
        end
    end

    // outputs change on the falling edge
    always @(negedge clk) begin
        if (!rstn) begin
            rnd     <= SEED;
            arready <= 1'b0;
            awready <= 1'b0;
            wready  <= 1'b0;
            rvalid  <= 1'b0;
            bvalid  <= 1'b0;
            r       <= '0;
        end else begin
            rnd_v = lfsr_step(rnd);
            arready <= rnd_v[0];
            rnd_v = lfsr_step(rnd_v);
            awready <= rnd_v[0];
            rnd_v = lfsr_step(rnd_v);
            wready <= rnd_v[0];
            rnd_v = lfsr_step(rnd_v);
            // a beat that was not taken stays on the bus
            if (!(rvalid && !r_taken)) begin
                if (rd_pend && rnd_v[0]) begin
                    rvalid <= 1'b1;
                    r.data <= rd_addr ^ PATTERN_KEY;
                    r.last <= rd_left == 8'd0;
                end else begin
                    rvalid <= 1'b0;
                end
            end
            rnd_v = lfsr_step(rnd_v);
            if (!(bvalid && !b_taken)) begin
                bvalid <= b_pend && rnd_v[0];
            end
            rnd <= rnd_v;
        end
    end

endmodule

//--- testbench/tb_cache_axi_bridge.sv
`timescale 1ns/1ps

`include "axi_bridge_settings.svh"

module tb_cache_axi_bridge;

    localparam logic [31:0] MEM_KEY = 32'h5a3c_96e1;
    localparam int          TIMEOUT = 400;

    logic                           clk;
    logic                           rstn;
    cache_req_pkg::cache_req_code_t req;
    cache_req_pkg::cache_block_t    wblock;
    logic [31:0]                    ad;
    logic [3:0]                     rword_en;
    logic                           task_finish;
    cache_req_pkg::cache_block_t    rblock;
    logic [31:0]                    rword;
    axi_pkg::axi_addr_t             ar;
    axi_pkg::axi_addr_t             aw;
    logic                           arvalid;
    logic                           arready;
    logic                           awvalid;
    logic                           awready;
    axi_pkg::axi_beat_t             r;
    axi_pkg::axi_beat_t             w;
    logic                           rvalid;
    logic                           rready;
    logic [3:0]                     wstrb;
    logic                           wvalid;
    logic                           wready;
    logic                           bvalid;
    logic                           bready;
    logic [3:0]                     arid;
    logic [3:0]                     awid;
    logic [3:0]                     wid;
    logic [1:0]                     arlock;
    logic [1:0]                     awlock;
    logic [3:0]                     arcache;
    logic [3:0]                     awcache;
    logic [2:0]                     arprot;
    logic [2:0]                     awprot;

    cache_req_pkg::cache_kind_t     exp_kind;
    axi_pkg::axi_addr_t             exp_addr;
    logic [31:0]                    exp_word;
    cache_req_pkg::cache_block_t    exp_block;
    logic [31:0]                    exp_wdata;
    string                          test_name;
    logic                           started;
    logic                           timed_out;
    logic [3:0]                     w_idx;
    int                             issued;
    int                             finish_cnt;
    int                             check_errors;
    int                             timeout_errors;

    cache_axi_bridge u_cache_axi_bridge (
        .clk(clk), .rstn(rstn), .req(req), .wblock(wblock), .ad(ad),
        .rword_en(rword_en), .task_finish(task_finish), .rblock(rblock), .rword(rword),
        .ar(ar), .arvalid(arvalid), .arready(arready),
        .aw(aw), .awvalid(awvalid), .awready(awready),
        .arid(arid), .awid(awid), .wid(wid), .arlock(arlock), .arcache(arcache),
        .arprot(arprot), .awlock(awlock), .awcache(awcache), .awprot(awprot),
        .r(r), .rvalid(rvalid), .rready(rready),
        .w(w), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bvalid(bvalid), .bready(bready)
    );

    axi_slave_model #(.PATTERN_KEY(MEM_KEY), .SEED(32'hec9b_3652)) u_slave (
        .clk(clk), .rstn(rstn), .ar(ar), .arvalid(arvalid), .arready(arready),
        .awvalid(awvalid), .awready(awready), .r(r), .rvalid(rvalid),
        .rready(rready), .w(w), .wvalid(wvalid), .wready(wready),
        .bvalid(bvalid), .bready(bready)
    );

    always #20 clk = ~clk;

    assign exp_wdata = exp_block[w_idx[2:0]*32 +: 32];

    always @(posedge clk) begin
        if (!rstn) begin
            w_idx      <= 4'd0;
            finish_cnt <= 0;
        end else if (task_finish) begin
            w_idx      <= 4'd0;
            finish_cnt <= finish_cnt + 1;
        end else if (wvalid && wready) begin
            w_idx <= w_idx + 4'd1;
        end
    end

    a_idle_after_reset: assert property (@(posedge clk) disable iff (!rstn)
        !started |-> !(arvalid || awvalid || wvalid || rready || bready || task_finish))
        else begin
            check_errors++;
            $display("a valid, ready or task_finish rose before the first request");
        end
    a_ar_fields: assert property (@(posedge clk) disable iff (!rstn)
        arvalid |-> exp_kind != cache_req_pkg::KIND_STORE_BLOCK && ar == exp_addr)
        else begin
            check_errors++;
            $display("error %s ar: expected %h, actual %h", test_name, exp_addr, $sampled(ar));
        end
    a_aw_fields: assert property (@(posedge clk) disable iff (!rstn)
        awvalid |-> exp_kind == cache_req_pkg::KIND_STORE_BLOCK && aw == exp_addr)
        else begin
            check_errors++;
            $display("error %s aw: expected %h, actual %h", test_name, exp_addr, $sampled(aw));
        end
    a_ar_attrs: assert property (@(posedge clk) disable iff (!rstn)
        arvalid |-> {arid, arlock, arcache, arprot} ==
            {`AXI_READ_ID, `AXI_LOCK_CODE, `AXI_CACHE_CODE, `AXI_PROT_CODE})
        else begin
            check_errors++;
            $display("error %s ar attributes: expected %h, actual %h", test_name,
                {`AXI_READ_ID, `AXI_LOCK_CODE, `AXI_CACHE_CODE, `AXI_PROT_CODE},
                {arid, arlock, arcache, arprot});
        end
    a_aw_attrs: assert property (@(posedge clk) disable iff (!rstn)
        awvalid |-> {awid, awlock, awcache, awprot} ==
            {`AXI_WRITE_ID, `AXI_LOCK_CODE, `AXI_CACHE_CODE, `AXI_PROT_CODE})
        else begin
            check_errors++;
            $display("error %s aw attributes: expected %h, actual %h", test_name,
                {`AXI_WRITE_ID, `AXI_LOCK_CODE, `AXI_CACHE_CODE, `AXI_PROT_CODE},
                {awid, awlock, awcache, awprot});
        end
    a_wid: assert property (@(posedge clk) disable iff (!rstn)
        wvalid |-> wid == `AXI_WRITE_ID)
        else begin
            check_errors++;
            $display("error %s wid: expected %h, actual %h", test_name, `AXI_WRITE_ID, wid);
        end
    a_ar_hold: assert property (@(posedge clk) disable iff (!rstn)
        arvalid && !arready |=> arvalid && $stable(ar))
        else begin
            check_errors++;
            $display("arvalid or ar changed before arready in test %s", test_name);
        end
    a_aw_hold: assert property (@(posedge clk) disable iff (!rstn)
        awvalid && !awready |=> awvalid && $stable(aw))
        else begin
            check_errors++;
            $display("awvalid or aw changed before awready in test %s", test_name);
        end
    a_w_data: assert property (@(posedge clk) disable iff (!rstn)
        wvalid && wready |-> w.data == exp_wdata)
        else begin
            check_errors++;
            $display("error %s w beat %0d: expected %h, actual %h", test_name,
                $sampled(w_idx), $sampled(exp_wdata), $sampled(w.data));
        end
    a_w_last: assert property (@(posedge clk) disable iff (!rstn)
        wvalid && wready |-> w.last == (w_idx == 4'd7))
        else begin
            check_errors++;
            $display("error %s wlast: expected %b, actual %b", test_name,
                $sampled(w_idx) == 4'd7, $sampled(w.last));
        end
    a_wstrb: assert property (@(posedge clk) disable iff (!rstn)
        wvalid |-> wstrb == 4'hf)
        else begin
            check_errors++;
            $display("error %s wstrb: expected f, actual %h", test_name, $sampled(wstrb));
        end
    a_rblock: assert property (@(posedge clk) disable iff (!rstn)
        task_finish && exp_kind == cache_req_pkg::KIND_LOAD_BLOCK |-> rblock == exp_block)
        else begin
            check_errors++;
            $display("error %s rblock: expected %h, actual %h", test_name, exp_block,
                $sampled(rblock));
        end
    a_rword: assert property (@(posedge clk) disable iff (!rstn)
        task_finish && exp_kind == cache_req_pkg::KIND_LOAD_WORD |-> rword == exp_word)
        else begin
            check_errors++;
            $display("error %s rword: expected %h, actual %h", test_name, exp_word,
                $sampled(rword));
        end
    a_store_end: assert property (@(posedge clk) disable iff (!rstn)
        task_finish && exp_kind == cache_req_pkg::KIND_STORE_BLOCK |->
            $past(bvalid && bready) && w_idx == 4'd8)
        else begin
            check_errors++;
            $display("store %s finished without eight w beats and a b transfer", test_name);
        end
    a_one_finish: assert property (@(posedge clk) disable iff (!rstn)
        task_finish |-> finish_cnt + 1 == issued)
        else begin
            check_errors++;
            $display("error %s finish count: expected %0d, actual %0d", test_name,
                issued, $sampled(finish_cnt) + 1);
        end
    a_single_start: assert property (@(posedge clk) disable iff (!rstn)
        $rose(arvalid || awvalid) |-> finish_cnt < issued)
        else begin
            check_errors++;
            $display("an address valid rose with no request outstanding in test %s",
                test_name);
        end

    function automatic logic [31:0] block_base(input logic [31:0] a);
        return {a[31:5], 5'b0};
    endfunction

    function automatic axi_pkg::axi_size_t size_for_enables(input logic [3:0] en);
        if (en == 4'b1111) begin
            return axi_pkg::SIZE_WORD;
        end else if (en == 4'b1100 || en == 4'b0011) begin
            return axi_pkg::SIZE_HALF;
        end
        return axi_pkg::SIZE_BYTE;
    endfunction

    function automatic cache_req_pkg::cache_block_t make_block(input logic [31:0] tag);
        cache_req_pkg::cache_block_t b;
        for (int i = 0; i < 8; i++) begin
            b[i*32 +: 32] = tag ^ (32'h0101_0101 * (i + 1));
        end
        return b;
    endfunction

    task automatic run_request(input cache_req_pkg::cache_req_code_t code,
                               input logic [31:0] addr, input logic [3:0] en,
                               input cache_req_pkg::cache_block_t blk, input string name);
        int cycles;
        cycles              = 0;
        exp_word            = addr ^ MEM_KEY;
        exp_addr.addr       = block_base(addr);
        exp_addr.len        = 8'd7;
        exp_addr.size       = axi_pkg::SIZE_WORD;
        exp_addr.burst      = axi_pkg::BURST_INCR;
        exp_block           = blk;
        if (code == cache_req_pkg::REQ_LOAD_BLOCK) begin
            exp_kind = cache_req_pkg::KIND_LOAD_BLOCK;
            for (int i = 0; i < 8; i++) begin
                exp_block[i*32 +: 32] = (block_base(addr) + 32'(4 * i)) ^ MEM_KEY;
            end
        end else if (code == cache_req_pkg::REQ_LOAD_WORD) begin
            exp_kind       = cache_req_pkg::KIND_LOAD_WORD;
            exp_addr.addr  = addr;
            exp_addr.len   = 8'd0;
            exp_addr.size  = size_for_enables(en);
            exp_addr.burst = axi_pkg::BURST_FIXED;
        end else begin
            exp_kind = cache_req_pkg::KIND_STORE_BLOCK;
        end
        test_name = name;
        ad        = addr;
        rword_en  = en;
        wblock    = blk;
        req       = code;
        started   = 1'b1;
        issued++;
        // req stays up for the whole transaction
        while (!task_finish && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!task_finish) begin
            timed_out = 1'b1;
            timeout_errors++;
            $display("timeout: no task_finish within %0d cycles in test %s", TIMEOUT, name);
        end
        // still high at the edge that closes the finish cycle
        @(negedge clk);
        req = cache_req_pkg::REQ_IDLE;
        repeat (2) @(negedge clk);
    endtask

    task automatic finish_run();
        $display("checks failed: %0d, timeouts: %0d", check_errors, timeout_errors);
        if (check_errors == 0 && timeout_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    initial begin
        clk            = 1'b0;
        rstn           = 1'b0;
        req            = cache_req_pkg::REQ_IDLE;
        wblock         = '0;
        ad             = '0;
        rword_en       = 4'h0;
        exp_kind       = cache_req_pkg::KIND_LOAD_BLOCK;
        exp_addr       = '0;
        exp_word       = '0;
        exp_block      = '0;
        test_name      = "reset";
        started        = 1'b0;
        timed_out      = 1'b0;
        issued         = 0;
        check_errors   = 0;
        timeout_errors = 0;
        repeat (3) @(negedge clk);
        rstn = 1'b1;
        repeat (3) @(negedge clk);
        for (int k = 0; k < 2; k++) begin
            if (!timed_out) begin
                run_request(cache_req_pkg::REQ_LOAD_BLOCK, 32'h0000_2a74 + 32'(k * 32'h1000),
                    4'h0, '0, "block_load");
            end
            if (!timed_out) begin
                run_request(cache_req_pkg::REQ_LOAD_WORD, 32'h0000_1238 + 32'(k * 4),
                    4'b1111, '0, "word_load_word");
            end
            if (!timed_out) begin
                run_request(cache_req_pkg::REQ_LOAD_WORD, 32'h0000_1242, 4'b1100, '0,
                    "word_load_half_hi");
            end
            if (!timed_out) begin
                run_request(cache_req_pkg::REQ_LOAD_WORD, 32'h0000_1250, 4'b0011, '0,
                    "word_load_half_lo");
            end
            if (!timed_out) begin
                run_request(cache_req_pkg::REQ_LOAD_WORD, 32'h0000_1263, 4'b1000, '0,
                    "word_load_byte");
            end
            if (!timed_out) begin
                run_request(cache_req_pkg::REQ_STORE_BLOCK, 32'h0000_4c1c + 32'(k * 32'h40),
                    4'h0, make_block(32'hc0de_0000 + 32'(k)), "block_store");
            end
        end
        // idle gap catches a second transaction from a held request
        repeat (6) @(negedge clk);
        finish_run();
    end

endmodule
